/* Makefile */
# Verilator build and run for the ORAM cipher stage

VERILATOR ?= verilator
TOP       ?= oramCryptTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* dv/oramCryptChecker.sv */
//----------------------------------------------------------------------
// ORAM cipher stage checker
// Predicts every output burst from accepted inputs and compares
//----------------------------------------------------------------------
`timescale 1ns/1ns

module oramCryptChecker import oramGeomPkg::*, oramCipherPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  logic  dramInitDone,
    input  burstT dramReadData,
    input  logic  dramReadValid,
    input  logic  dramReadReady,
    input  burstT backendWData,
    input  logic  backendWValid,
    input  logic  backendWReady,
    input  burstT dramWriteData,
    input  logic  dramWriteValid,
    input  logic  dramWriteReady,
    input  burstT backendRData,
    input  logic  backendRValid,
    input  logic  backendRReady,
    output int    errorCount,
    output int    outCount,
    output int    pendingCount
);

    burstT    expQ [$];
    burstIdxT bucketIdx;
    ivT       ivLatched;
    int       pathOut;
    logic     dirRead;

    initial begin
        errorCount   = 0;
        outCount     = 0;
        pendingCount = 0;
    end

    //------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------

    // Key whitening, then add, rotate left and key per round
    function automatic laneT mixLane(laneT x);
        laneT v;
        v = x ^ CipherKey;
        for (int r = 0; r < MixRounds; r++) begin
            v = v + RoundConst[r];
            v = {v[LaneWidth-MixRotate-1:0], v[LaneWidth-1:LaneWidth-MixRotate]};
            v = v ^ CipherKey;
        end
        return v;
    endfunction

    function automatic burstT refOutput(burstT data, logic isHeader, ivT iv, burstIdxT idx);
        ivT    counter;
        burstT pad;
        burstT res;
        if (isHeader) begin
            counter = data[IvWidth-1:0];
        end else begin
            counter = iv + ivT'(2 * int'(idx));
        end
        for (int k = 0; k < Lanes; k++) begin
            pad[k*LaneWidth +: LaneWidth] = mixLane(laneT'(counter) + laneT'(k));
        end
        res = data ^ pad;
        if (isHeader) begin
            res[IvWidth-1:0] = data[IvWidth-1:0];
        end
        return res;
    endfunction

    task automatic checkOutput(logic fire, logic onRead, burstT got, string name);
        burstT exp;
        if (fire) begin
            if (expQ.size() == 0) begin
                $display("Error: %s transfer with no burst pending at %0t", name, $time);
                errorCount++;
            end else begin
                exp = expQ.pop_front();
                if (onRead != dirRead) begin
                    $display("Error: burst left on %s during a path %s at %0t",
                             name, dirRead ? "read" : "write", $time);
                    errorCount++;
                end
                if (got !== exp) begin
                    $display("Mismatch %s: expected %h, got %h", name, exp, got);
                    errorCount++;
                end
            end
            outCount++;
            pathOut++;
            if (pathOut == PathBursts) begin
                pathOut = 0;
                dirRead = !dirRead;
            end
        end
    endtask

    //------------------------------------------------------------------
    // Sampling at the falling edge, where every handshake is settled
    //------------------------------------------------------------------

    always @(negedge Clock) begin
        logic  acceptW;
        logic  acceptR;
        logic  isHeader;
        burstT inData;
        if (!dramInitDone && (dramReadReady || backendWReady || dramWriteValid
                              || backendRValid)) begin
            $display("Error: handshake active before DRAM initialisation at %0t", $time);
            errorCount++;
        end
        if (backendWValid && dramReadReady) begin
            $display("Error: dramReadReady high while a backend write is offered at %0t",
                     $time);
            errorCount++;
        end
        if (!rstN) begin
            bucketIdx = '0;
            pathOut   = 0;
            dirRead   = 1'b1;
            expQ.delete();
        end else begin
            acceptW = backendWValid && backendWReady;
            acceptR = dramReadValid && dramReadReady;
            if (acceptW && acceptR) begin
                $display("Error: both inputs accepted in one cycle at %0t", $time);
                errorCount++;
            end
            if (acceptW || acceptR) begin
                inData   = acceptW ? backendWData : dramReadData;
                isHeader = (bucketIdx == '0);
                if (isHeader) begin
                    ivLatched = inData[IvWidth-1:0];
                end
                expQ.push_back(refOutput(inData, isHeader, ivLatched, bucketIdx));
                bucketIdx = (bucketIdx == burstIdxT'(BucketBursts - 1)) ? '0
                                                                        : bucketIdx + 1'b1;
            end
            if (backendRValid && dramWriteValid) begin
                $display("Error: both output valids high at %0t", $time);
                errorCount++;
            end
            checkOutput(backendRValid && backendRReady, 1'b1, backendRData, "backendRData");
            checkOutput(dramWriteValid && dramWriteReady, 1'b0, dramWriteData, "dramWriteData");
        end
        pendingCount = expQ.size();
    end

endmodule

/* dv/oramCryptTb.sv */
//----------------------------------------------------------------------
// ORAM cipher stage testbench
// Drives path reads and writes with random data, stalls and gaps
//----------------------------------------------------------------------
`timescale 1ns/1ns

module oramCryptTb import oramGeomPkg::*; ();

    localparam int ClockPeriod   = 40;
    localparam int DriveDelay    = 2;
    localparam int ResetCycles   = 4;
    localparam int NumTests      = 5;
    localparam int PathsRun      = 5;
    localparam int TotalBursts   = PathsRun * PathBursts;
    localparam int TimeoutCycles = 20 * TotalBursts + 200;
    localparam logic [31:0] Seed = 32'ha7ed248d;

    logic        Clock;
    logic        rstN;
    logic        dramInitDone;
    burstT       dramReadData;
    logic        dramReadValid;
    logic        dramReadReady;
    burstT       dramWriteData;
    logic        dramWriteValid;
    logic        dramWriteReady;
    burstT       backendWData;
    logic        backendWValid;
    logic        backendWReady;
    burstT       backendRData;
    logic        backendRValid;
    logic        backendRReady;
    int          chkErrors;
    int          outCount;
    int          pending;
    int          failedTests;
    int          cycleCount;
    logic [31:0] dataState;
    logic [31:0] stallState;

    oramCryptTop oramCryptTop_inst (
        .Clock(Clock), .rstN(rstN),
        .dramReadData(dramReadData), .dramReadValid(dramReadValid),
        .dramReadReady(dramReadReady),
        .dramWriteData(dramWriteData), .dramWriteValid(dramWriteValid),
        .dramWriteReady(dramWriteReady),
        .backendWData(backendWData), .backendWValid(backendWValid),
        .backendWReady(backendWReady),
        .backendRData(backendRData), .backendRValid(backendRValid),
        .backendRReady(backendRReady),
        .dramInitDone(dramInitDone)
    );

    oramCryptChecker outChecker (
        .Clock(Clock), .rstN(rstN), .dramInitDone(dramInitDone),
        .dramReadData(dramReadData), .dramReadValid(dramReadValid),
        .dramReadReady(dramReadReady),
        .backendWData(backendWData), .backendWValid(backendWValid),
        .backendWReady(backendWReady),
        .dramWriteData(dramWriteData), .dramWriteValid(dramWriteValid),
        .dramWriteReady(dramWriteReady),
        .backendRData(backendRData), .backendRValid(backendRValid),
        .backendRReady(backendRReady),
        .errorCount(chkErrors), .outCount(outCount), .pendingCount(pending)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    // Run limit scaled to the number of bursts
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycleCount);
        $display("Simulation FAILED");
        $finish;
    end

    //------------------------------------------------------------------
    // Stimulus helpers
    //------------------------------------------------------------------

    function automatic logic [31:0] lcgNext(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic burstT randomBurst();
        return {lcgNext(dataState), lcgNext(dataState), lcgNext(dataState),
                lcgNext(dataState)};
    endfunction

    task automatic nextDrive();
        @(posedge Clock);
        #DriveDelay;
    endtask

    // Mode 0 is a DRAM read, 1 a backend write, 2 a backend write with DRAM also offered
    task automatic sendBurst(int mode, burstT data);
        logic taken;
        taken = 1'b0;
        if (mode == 0) begin
            dramReadData  = data;
            dramReadValid = 1'b1;
        end else begin
            backendWData  = data;
            backendWValid = 1'b1;
        end
        while (!taken) begin
            @(negedge Clock);
            taken = (mode == 0) ? dramReadReady : backendWReady;
            nextDrive();
        end
        if (mode == 0) begin
            dramReadValid = 1'b0;
        end else begin
            backendWValid = 1'b0;
        end
    endtask

    task automatic drivePathInputs(int mode);
        logic [31:0] r;
        if (mode == 2) begin
            dramReadData  = randomBurst();
            dramReadValid = 1'b1;
        end
        for (int i = 0; i < PathBursts; i++) begin
            r = lcgNext(dataState);
            // No gaps while both sources are offered
            if (mode != 2 && r[25:24] == 2'b00) begin
                repeat (int'(r[27:26]) + 1) nextDrive();
            end
            sendBurst(mode, randomBurst());
        end
        dramReadValid = 1'b0;
    endtask

    task automatic driveOutputReady(int target, logic stall);
        logic [31:0] r;
        while (outCount < target) begin
            nextDrive();
            r = lcgNext(stallState);
            backendRReady  = !stall || r[20] || r[21];
            dramWriteReady = !stall || r[22] || r[23];
        end
        backendRReady  = 1'b1;
        dramWriteReady = 1'b1;
    endtask

    task automatic runPath(int mode, logic stall);
        int target;
        target = outCount + PathBursts;
        fork
            drivePathInputs(mode);
            driveOutputReady(target, stall);
        join
    endtask

    task automatic reportTest(int num, string name, int errorsBefore);
        int errs;
        errs = chkErrors - errorsBefore;
        $display("Test %0d %s: %0d error(s)", num, name, errs);
        if (errs != 0) begin
            failedTests++;
        end
    endtask

    //------------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------------

    initial begin
        int errorsBefore;
        dataState      = Seed;
        stallState     = lcgNext(dataState);
        failedTests    = 0;
        rstN           = 1'b0;
        dramInitDone   = 1'b0;
        dramReadData   = randomBurst();
        backendWData   = randomBurst();
        // Inputs offered during reset must stay untaken
        dramReadValid  = 1'b1;
        backendWValid  = 1'b1;
        dramWriteReady = 1'b1;
        backendRReady  = 1'b1;

        errorsBefore = chkErrors;
        repeat (ResetCycles) @(posedge Clock);
        #DriveDelay;
        rstN = 1'b1;
        repeat (6) nextDrive();
        dramReadValid = 1'b0;
        backendWValid = 1'b0;
        nextDrive();
        dramInitDone = 1'b1;
        reportTest(1, "idle before init", errorsBefore);

        errorsBefore = chkErrors;
        runPath(0, 1'b0);
        reportTest(2, "path read", errorsBefore);

        errorsBefore = chkErrors;
        runPath(1, 1'b0);
        reportTest(3, "path write", errorsBefore);

        errorsBefore = chkErrors;
        runPath(0, 1'b1);
        runPath(1, 1'b1);
        reportTest(4, "back-pressure", errorsBefore);

        errorsBefore = chkErrors;
        runPath(2, 1'b0);
        reportTest(5, "write priority", errorsBefore);

        repeat (2) nextDrive();
        if (pending != 0) begin
            $display("%0d expected bursts never left the DUT", pending);
            failedTests++;
        end
        $display("Tests run: %0d, tests with errors: %0d, checker errors: %0d",
                 NumTests, failedTests, chkErrors);
        if (failedTests == 0 && chkErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* logic/bucketFramer.sv */
//--------------------------------------------------------------------
// Bucket framer
// Picks the input source, tracks the bucket position and requests pads
//--------------------------------------------------------------------
`timescale 1ns/1ns

module bucketFramer import oramGeomPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  logic       dramInitDone,
    input  burstT      dramReadData,
    input  logic       dramReadValid,
    output logic       dramReadReady,
    input  burstT      backendWData,
    input  logic       backendWValid,
    output logic       backendWReady,
    input  logic       dataFull,
    output logic       dataWrEn,
    output burstEntryT dataEntry,
    output ksReqT      ksReq
);

    burstIdxT burstIdx;
    ivT       ivReg;
    logic     acceptW;
    logic     acceptR;
    logic     accept;
    logic     isHeader;
    burstT    burstIn;

    //----------------------------------------------------------------------
    // Source select
    //----------------------------------------------------------------------

    // Backend write wins over a DRAM read
    assign backendWReady = dramInitDone && !dataFull;
    assign dramReadReady = dramInitDone && !dataFull && !backendWValid;

    assign acceptW  = backendWValid && backendWReady;
    assign acceptR  = dramReadValid && dramReadReady;
    assign accept   = acceptW || acceptR;
    assign burstIn  = acceptW ? backendWData : dramReadData;
    assign isHeader = (burstIdx == '0);

    //----------------------------------------------------------------------
    // Entry and keystream request
    //----------------------------------------------------------------------

    assign dataWrEn           = accept;
    assign dataEntry.data     = burstIn;
    assign dataEntry.isHeader = isHeader;

    assign ksReq.valid = accept;
    // Header uses its own IV
    // Later bursts step by one pad word
    assign ksReq.counter = isHeader ? burstIn[IvWidth-1:0]
                                    : ivReg + ivT'(Lanes) * ivT'(burstIdx);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            burstIdx <= '0;
        end else if (accept) begin
            burstIdx <= (burstIdx == burstIdxT'(BucketBursts - 1)) ? '0 : burstIdx + 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (accept && isHeader) begin
            ivReg <= burstIn[IvWidth-1:0];
        end
    end

endmodule

/* logic/keystreamPipe.sv */
//--------------------------------------------------------------------
// Keystream pipe
// Four registered add-rotate-xor rounds per lane without a stall input
//--------------------------------------------------------------------
`timescale 1ns/1ns

module keystreamPipe import oramGeomPkg::*, oramCipherPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  ksReqT ksReq,
    output logic  padValid,
    output burstT pad
);

    logic [MixRounds-1:0] validQ;

    // One round of the lane mixer
    function automatic laneT mixRound(laneT x, int unsigned r);
        laneT sum;
        laneT rot;
        sum = x + laneT'(RoundConst[r]);
        rot = (sum << MixRotate) | (sum >> (LaneWidth - MixRotate));
        return rot ^ laneT'(CipherKey);
    endfunction

    //----------------------------------------------------------------------
    // Lane datapath
    //----------------------------------------------------------------------

    for (genvar k = 0; k < Lanes; k++) begin : gLane
        laneT laneIn;
        laneT stageQ [MixRounds];

        // Lane k mixes counter plus k after key whitening
        assign laneIn = (laneT'(ksReq.counter) + laneT'(k)) ^ laneT'(CipherKey);

        always_ff @(posedge Clock) begin
            stageQ[0] <= mixRound(laneIn, 0);
            for (int r = 1; r < MixRounds; r++) begin
                stageQ[r] <= mixRound(stageQ[r-1], r);
            end
        end

        // Lane 0 lands in the low bits
        assign pad[k*LaneWidth +: LaneWidth] = stageQ[MixRounds-1];
    end

    //----------------------------------------------------------------------
    // Valid tracking
    //----------------------------------------------------------------------

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            validQ <= '0;
        end else begin
            validQ <= {validQ[MixRounds-2:0], ksReq.valid};
        end
    end

    assign padValid = validQ[MixRounds-1];

endmodule

/* logic/oramCipherPkg.sv */
//--------------------------------------------------------------------
// Lane mixer constants
// Key, round constants and rotate amount of the keystream rounds
//--------------------------------------------------------------------
package oramCipherPkg;

    localparam int KeyWidth  = 64;

    // Fixed key without a load path
    localparam logic [KeyWidth-1:0] CipherKey = '1;

    // One registered round per pipe stage
    localparam int MixRounds = 4;
    localparam int MixRotate = 13;

    // Nothing-up-my-sleeve round constants
    localparam logic [KeyWidth-1:0] RoundConst [MixRounds] = '{
        64'h9E3779B97F4A7C15,
        64'hBB67AE8584CAA73B,
        64'h3C6EF372FE94F82B,
        64'hA54FF53A5F1D36F1
    };

endpackage

/* logic/oramCryptTop.sv */
//--------------------------------------------------------------------
// ORAM counter-mode cipher stage
// Encrypts bucket bursts between the DRAM controller and the backend
//--------------------------------------------------------------------
`timescale 1ns/1ns

module oramCryptTop import oramGeomPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  burstT dramReadData,
    input  logic  dramReadValid,
    output logic  dramReadReady,
    output burstT dramWriteData,
    output logic  dramWriteValid,
    input  logic  dramWriteReady,
    input  burstT backendWData,
    input  logic  backendWValid,
    output logic  backendWReady,
    output burstT backendRData,
    output logic  backendRValid,
    input  logic  backendRReady,
    input  logic  dramInitDone
);

    logic       dataWrEn;
    burstEntryT dataIn;
    burstEntryT dataHead;
    logic       dataFull;
    logic       dataEmpty;
    ksReqT      ksReq;
    logic       padValid;
    burstT      pad;
    burstT      padHead;
    logic       padEmpty;
    logic       popEn;

    bucketFramer framer (
        .Clock(Clock), .rstN(rstN), .dramInitDone(dramInitDone),
        .dramReadData(dramReadData), .dramReadValid(dramReadValid),
        .dramReadReady(dramReadReady),
        .backendWData(backendWData), .backendWValid(backendWValid),
        .backendWReady(backendWReady),
        .dataFull(dataFull), .dataWrEn(dataWrEn), .dataEntry(dataIn), .ksReq(ksReq)
    );

    keystreamPipe ksPipe (
        .Clock(Clock), .rstN(rstN), .ksReq(ksReq), .padValid(padValid), .pad(pad)
    );

    syncFifo #(.Width($bits(burstEntryT)), .Depth(FifoDepth)) dataFifo (
        .Clock(Clock), .rstN(rstN), .wrEn(dataWrEn), .wrData(dataIn),
        .rdEn(popEn), .rdData(dataHead), .full(dataFull), .empty(dataEmpty)
    );

    // Pad entries never outnumber data entries
    syncFifo #(.Width(BurstWidth), .Depth(FifoDepth)) padFifo (
        .Clock(Clock), .rstN(rstN), .wrEn(padValid), .wrData(pad),
        .rdEn(popEn), .rdData(padHead), .full(), .empty(padEmpty)
    );

    pathSteer steer (
        .Clock(Clock), .rstN(rstN), .dramInitDone(dramInitDone),
        .dataEntry(dataHead), .dataEmpty(dataEmpty),
        .padData(padHead), .padEmpty(padEmpty), .popEn(popEn),
        .dramWriteData(dramWriteData), .dramWriteValid(dramWriteValid),
        .dramWriteReady(dramWriteReady),
        .backendRData(backendRData), .backendRValid(backendRValid),
        .backendRReady(backendRReady)
    );

endmodule

/* logic/oramGeomPkg.sv */
//--------------------------------------------------------------------
// ORAM bucket geometry package
// Burst, IV and lane widths plus the types shared by the cipher stage
//--------------------------------------------------------------------
package oramGeomPkg;

    // Burst and IV layout
    localparam int BurstWidth   = 128;
    localparam int IvWidth      = 64;
    localparam int LaneWidth    = 64;
    localparam int Lanes        = 2;

    // Bucket and path shape
    localparam int BucketBursts = 4;
    localparam int PathBuckets  = 3;
    localparam int PathBursts   = PathBuckets * BucketBursts;
    localparam int FifoDepth    = 8;

    typedef logic [BurstWidth-1:0]            burstT;
    typedef logic [IvWidth-1:0]               ivT;
    typedef logic [LaneWidth-1:0]             laneT;
    typedef logic [$clog2(BucketBursts)-1:0]  burstIdxT;
    typedef logic [$clog2(PathBursts)-1:0]    pathIdxT;

    // Data FIFO entry with the header flag riding along
    typedef struct packed {
        burstT data;
        logic  isHeader;
    } burstEntryT;

    typedef struct packed {
        logic valid;
        ivT   counter;
    } ksReqT;

    typedef enum logic {
        PathWrite = 1'b0,
        PathRead  = 1'b1
    } pathDirT;

endpackage

/* logic/pathSteer.sv */
//--------------------------------------------------------------------
// Path steer
// Applies the pad, restores header IVs and routes by path direction
//--------------------------------------------------------------------
`timescale 1ns/1ns

module pathSteer import oramGeomPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  logic       dramInitDone,
    input  burstEntryT dataEntry,
    input  logic       dataEmpty,
    input  burstT      padData,
    input  logic       padEmpty,
    output logic       popEn,
    output burstT      dramWriteData,
    output logic       dramWriteValid,
    input  logic       dramWriteReady,
    output burstT      backendRData,
    output logic       backendRValid,
    input  logic       backendRReady
);

    logic    started;
    pathDirT pathDir;
    pathIdxT pathCnt;
    logic    outValid;
    logic    activeReady;
    logic    pathEnd;
    burstT   xorRes;
    burstT   outData;

    //----------------------------------------------------------------------
    // Output datapath
    //----------------------------------------------------------------------

    assign xorRes = dataEntry.data ^ padData;

    // Header keeps the clear IV in its low bits
    always_comb begin
        outData = xorRes;
        if (dataEntry.isHeader) begin
            outData[IvWidth-1:0] = dataEntry.data[IvWidth-1:0];
        end
    end

    assign dramWriteData = outData;
    assign backendRData  = outData;

    //----------------------------------------------------------------------
    // Handshake
    //----------------------------------------------------------------------

    // Data and pad leave as a pair
    assign outValid    = started && !dataEmpty && !padEmpty;
    assign activeReady = (pathDir == PathRead) ? backendRReady : dramWriteReady;
    assign popEn       = outValid && activeReady;

    assign backendRValid  = outValid && (pathDir == PathRead);
    assign dramWriteValid = outValid && (pathDir == PathWrite);

    //----------------------------------------------------------------------
    // Direction and path count
    //----------------------------------------------------------------------

    assign pathEnd = popEn && (pathCnt == pathIdxT'(PathBursts - 1));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            started <= 1'b0;
            pathDir <= PathWrite;
            pathCnt <= '0;
        end else if (!started) begin
            // First path after DRAM init is a read
            if (dramInitDone) begin
                started <= 1'b1;
                pathDir <= PathRead;
            end
        end else if (pathEnd) begin
            pathCnt <= '0;
            pathDir <= (pathDir == PathRead) ? PathWrite : PathRead;
        end else if (popEn) begin
            pathCnt <= pathCnt + 1'b1;
        end
    end

endmodule

/* logic/syncFifo.sv */
//--------------------------------------------------------------------
// Synchronous FIFO
// Register array with head read-out, full and empty flags
//--------------------------------------------------------------------
`timescale 1ns/1ns

module syncFifo #(
    parameter int Width = 8,
    parameter int Depth = 8
) (
    input  logic             Clock,
    input  logic             rstN,
    input  logic             wrEn,
    input  logic [Width-1:0] wrData,
    input  logic             rdEn,
    output logic [Width-1:0] rdData,
    output logic             full,
    output logic             empty
);

    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntWidth = $clog2(Depth + 1);

    logic [Width-1:0]    mem [Depth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CntWidth-1:0] count;
    logic                doWrite;
    logic                doRead;

    assign full    = (count == CntWidth'(Depth));
    assign empty   = (count == '0);
    assign doRead  = rdEn && !empty;
    // A pop frees a slot in the same cycle
    assign doWrite = wrEn && (!full || doRead);

    // Head entry is meaningful while not empty
    assign rdData = mem[rdPtr];

    always_ff @(posedge Clock) begin
        if (doWrite) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog.f */
logic/oramGeomPkg.sv
logic/oramCipherPkg.sv
logic/syncFifo.sv
logic/bucketFramer.sv
logic/keystreamPipe.sv
logic/pathSteer.sv
logic/oramCryptTop.sv
dv/oramCryptChecker.sv
dv/oramCryptTb.sv
